//--- include/atom_params.svh
/*
 * Atom core build parameters
 * Widths, register count, reset vector and the pipeline bubble
 */
`ifndef ATOM_PARAMS_SVH
`define ATOM_PARAMS_SVH

// Datapath
`define ATOM_XLEN       32              // Data and address width
`define ATOM_NREGS      32              // x0..x31
`define ATOM_REG_IDX_W  5               // Register select width

// Fetch
`define ATOM_RESET_PC   32'h0000_0000   // First fetch address
`define ATOM_NOP        32'h0000_0013   // addi x0, x0, 0

`endif

//--- hdl/atom_isa_pkg.sv
/*
 * RV32I encoding types
 * Major opcodes, ALU operations, comparison kinds and access widths
 */
package atom_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_op_e;

    // Comparator functions
    typedef enum logic [2:0] {
        CMP_ALWAYS,                     // Unconditional jumps
        CMP_EQ, CMP_NE,
        CMP_LT, CMP_GE,                 // Signed
        CMP_LTU, CMP_GEU,               // Unsigned
        CMP_NEVER
    } cmp_op_e;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_width_e;

endpackage

//--- hdl/atom_pipe_pkg.sv
/*
 * Pipeline types
 * Decoded control bundle, data-memory request, write-back source
 */
`include "atom_params.svh"

package atom_pipe_pkg;

    typedef enum logic [2:0] {
        WB_IMM, WB_LINK, WB_ALU, WB_CMP, WB_LOAD
    } wb_src_e;

    // Stage 2 control, one per decoded instruction
    typedef struct packed {
        logic                     jump_en;
        atom_isa_pkg::cmp_op_e    cmp_op;
        logic                     rf_we;
        wb_src_e                  wb_src;
        logic                     a_sel_pc;       // ALU A is PC
        logic                     b_sel_imm;      // ALU B is imm
        logic                     cmp_b_sel_imm;  // Comparator B is imm
        atom_isa_pkg::alu_op_e    alu_op;
        logic                     mem_en;
        logic                     mem_we;
        atom_isa_pkg::mem_width_e mem_width;
        logic                     mem_unsigned;
    } ctrl_t;

    typedef struct packed {
        logic [`ATOM_XLEN-1:0]   addr;     // Word aligned
        logic [`ATOM_XLEN-1:0]   wdata;
        logic [`ATOM_XLEN/8-1:0] sel;      // Byte lanes
        logic                    we;
    } dmem_req_t;

endpackage

//--- hdl/atom_fetch.sv
/*
 * Fetch stage of the atom core
 * PC, instruction register and the stall/flush/stale-fetch control
 */
`include "atom_params.svh"

module atom_fetch (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [`ATOM_XLEN-1:0] imem_data_i,
    input  logic                  imem_ack_i,
    input  logic                  jump_en_i,
    input  logic                  cmp_true_i,
    input  logic [`ATOM_XLEN-1:0] jump_target_i,
    input  logic                  dmem_valid_i,
    input  logic                  dmem_ack_i,
    output logic [`ATOM_XLEN-1:0] imem_addr_o,
    output logic                  imem_valid_o,
    output logic [`ATOM_XLEN-1:0] instr_o,
    output logic [`ATOM_XLEN-1:0] pc_old_o,
    output logic [`ATOM_XLEN-1:0] link_addr_o,
    output logic                  stall_ex_o
);
    logic [`ATOM_XLEN-1:0] pc_q;
    logic [`ATOM_XLEN-1:0] pc_plus4;
    logic                  ignore_q;    // Fetch in flight across a jump is stale
    logic                  jump;
    logic                  raw_imem_hs;
    logic                  imem_hs;
    logic                  stall_if;
    logic                  flush;

    ////////////////////////////////////////
    // Pipeline control
    assign jump        = jump_en_i & cmp_true_i;
    assign raw_imem_hs = imem_valid_o & imem_ack_i;
    assign imem_hs     = raw_imem_hs & ~ignore_q;
    assign stall_ex_o  = dmem_valid_i & ~dmem_ack_i;  // Data request not yet acked
    assign stall_if    = ~imem_hs | stall_ex_o;
    assign flush       = jump | (stall_if & ~stall_ex_o); // Jump or fetch bubble

    assign pc_plus4    = pc_q + `ATOM_XLEN'd4;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            imem_valid_o <= 1'b0;
            ignore_q     <= 1'b0;
        end else begin
            imem_valid_o <= 1'b1;           // Fetch runs from the first cycle after reset
            if (jump)
                ignore_q <= 1'b1;
            else if (raw_imem_hs)
                ignore_q <= 1'b0;           // Stale word has arrived
        end
    end

    ////////////////////////////////////////
    // Program counter and stage registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q    <= `ATOM_RESET_PC;
            instr_o <= `ATOM_NOP;
        end else begin
            if (jump)
                pc_q <= {jump_target_i[`ATOM_XLEN-1:1], 1'b0};  // Even aligned target
            else if (!stall_if)
                pc_q <= pc_plus4;
            if (flush)
                instr_o <= `ATOM_NOP;
            else if (!stall_if)
                instr_o <= imem_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_if) begin
            pc_old_o    <= pc_q;            // PC of the instruction entering stage 2
            link_addr_o <= pc_plus4;
        end
    end

endmodule

//--- hdl/atom_decode.sv
/*
 * Instruction decoder
 * Register selects, immediate and the stage 2 control bundle
 */
`include "atom_params.svh"

module atom_decode (
    input  logic [`ATOM_XLEN-1:0]      instr_i,
    output logic [`ATOM_REG_IDX_W-1:0] rd_sel_o,
    output logic [`ATOM_REG_IDX_W-1:0] rs1_sel_o,
    output logic [`ATOM_REG_IDX_W-1:0] rs2_sel_o,
    output logic [`ATOM_XLEN-1:0]      imm_o,
    output atom_pipe_pkg::ctrl_t       ctrl_o
);
    atom_isa_pkg::opcode_e opcode;
    logic [2:0]            funct3;
    logic                  alt;         // instr[30], SUB and SRA
    logic [`ATOM_XLEN-1:0] imm_i;
    logic [`ATOM_XLEN-1:0] imm_s;
    logic [`ATOM_XLEN-1:0] imm_b;
    logic [`ATOM_XLEN-1:0] imm_u;
    logic [`ATOM_XLEN-1:0] imm_j;

    assign opcode    = atom_isa_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign alt       = instr_i[30];
    assign rd_sel_o  = instr_i[11:7];
    assign rs1_sel_o = instr_i[19:15];
    assign rs2_sel_o = instr_i[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'd0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o        = '0;                         // All inactive by default
        ctrl_o.cmp_op = atom_isa_pkg::CMP_NEVER;
        imm_o         = imm_i;
        case (opcode)
            atom_isa_pkg::OPC_LUI: begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.wb_src = atom_pipe_pkg::WB_IMM;
                imm_o         = imm_u;
            end
            atom_isa_pkg::OPC_AUIPC: begin
                ctrl_o.rf_we     = 1'b1;
                ctrl_o.wb_src    = atom_pipe_pkg::WB_ALU;
                ctrl_o.a_sel_pc  = 1'b1;
                ctrl_o.b_sel_imm = 1'b1;
                imm_o            = imm_u;
            end
            atom_isa_pkg::OPC_JAL, atom_isa_pkg::OPC_JALR: begin
                ctrl_o.jump_en   = 1'b1;
                ctrl_o.cmp_op    = atom_isa_pkg::CMP_ALWAYS;
                ctrl_o.rf_we     = 1'b1;
                ctrl_o.wb_src    = atom_pipe_pkg::WB_LINK;
                ctrl_o.a_sel_pc  = (opcode == atom_isa_pkg::OPC_JAL); // JALR adds to rs1
                ctrl_o.b_sel_imm = 1'b1;
                imm_o            = (opcode == atom_isa_pkg::OPC_JAL) ? imm_j : imm_i;
            end
            atom_isa_pkg::OPC_BRANCH: begin
                ctrl_o.jump_en   = 1'b1;
                ctrl_o.a_sel_pc  = 1'b1;            // Target is PC + imm
                ctrl_o.b_sel_imm = 1'b1;
                imm_o            = imm_b;
                case (funct3)
                    3'b000:  ctrl_o.cmp_op = atom_isa_pkg::CMP_EQ;
                    3'b001:  ctrl_o.cmp_op = atom_isa_pkg::CMP_NE;
                    3'b100:  ctrl_o.cmp_op = atom_isa_pkg::CMP_LT;
                    3'b101:  ctrl_o.cmp_op = atom_isa_pkg::CMP_GE;
                    3'b110:  ctrl_o.cmp_op = atom_isa_pkg::CMP_LTU;
                    3'b111:  ctrl_o.cmp_op = atom_isa_pkg::CMP_GEU;
                    default: ctrl_o.cmp_op = atom_isa_pkg::CMP_NEVER;
                endcase
            end
            atom_isa_pkg::OPC_LOAD, atom_isa_pkg::OPC_STORE: begin
                ctrl_o.rf_we        = (opcode == atom_isa_pkg::OPC_LOAD);
                ctrl_o.wb_src       = atom_pipe_pkg::WB_LOAD;
                ctrl_o.b_sel_imm    = 1'b1;         // Address is rs1 + imm
                ctrl_o.mem_en       = 1'b1;
                ctrl_o.mem_we       = (opcode == atom_isa_pkg::OPC_STORE);
                ctrl_o.mem_width    = atom_isa_pkg::mem_width_e'(funct3[1:0]);
                ctrl_o.mem_unsigned = funct3[2];
                imm_o = (opcode == atom_isa_pkg::OPC_STORE) ? imm_s : imm_i;
            end
            atom_isa_pkg::OPC_OP_IMM, atom_isa_pkg::OPC_OP: begin
                ctrl_o.rf_we         = 1'b1;
                ctrl_o.wb_src        = atom_pipe_pkg::WB_ALU;
                ctrl_o.b_sel_imm     = (opcode == atom_isa_pkg::OPC_OP_IMM);
                ctrl_o.cmp_b_sel_imm = (opcode == atom_isa_pkg::OPC_OP_IMM);
                case (funct3)
                    3'b000: begin                   // No SUBI, imm bit 30 is data
                        if (alt && opcode == atom_isa_pkg::OPC_OP)
                            ctrl_o.alu_op = atom_isa_pkg::ALU_SUB;
                        else
                            ctrl_o.alu_op = atom_isa_pkg::ALU_ADD;
                    end
                    3'b001: ctrl_o.alu_op = atom_isa_pkg::ALU_SLL;
                    3'b010, 3'b011: begin           // SLT/SLTU via comparator
                        ctrl_o.wb_src = atom_pipe_pkg::WB_CMP;
                        ctrl_o.cmp_op = funct3[0] ? atom_isa_pkg::CMP_LTU
                                                  : atom_isa_pkg::CMP_LT;
                    end
                    3'b100: ctrl_o.alu_op = atom_isa_pkg::ALU_XOR;
                    3'b101: ctrl_o.alu_op = alt ? atom_isa_pkg::ALU_SRA
                                                : atom_isa_pkg::ALU_SRL;
                    3'b110: ctrl_o.alu_op = atom_isa_pkg::ALU_OR;
                    default: ctrl_o.alu_op = atom_isa_pkg::ALU_AND;
                endcase
            end
            default: ;                              // FENCE, SYSTEM, unknown: no-op
        endcase
    end

endmodule

//--- hdl/atom_regfile.sv
/*
 * Integer register file
 * Two asynchronous read ports, one write port, x0 reads as zero
 */
`include "atom_params.svh"

module atom_regfile (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [`ATOM_REG_IDX_W-1:0] rs1_sel_i,
    input  logic [`ATOM_REG_IDX_W-1:0] rs2_sel_i,
    input  logic [`ATOM_REG_IDX_W-1:0] rd_sel_i,
    input  logic                       we_i,
    input  logic [`ATOM_XLEN-1:0]      rd_data_i,
    output logic [`ATOM_XLEN-1:0]      rs1_o,
    output logic [`ATOM_XLEN-1:0]      rs2_o
);
    logic [`ATOM_XLEN-1:0] regs_q [`ATOM_NREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `ATOM_NREGS; i++)
                regs_q[i] <= '0;
        end else if (we_i) begin
            regs_q[rd_sel_i] <= rd_data_i;
        end
    end

    // x0 hardwired, whatever was written
    assign rs1_o = (rs1_sel_i == '0) ? '0 : regs_q[rs1_sel_i];
    assign rs2_o = (rs2_sel_i == '0) ? '0 : regs_q[rs2_sel_i];

endmodule

//--- hdl/atom_alu.sv
/*
 * Integer ALU
 * Operand selection plus add, subtract, logic and shifts
 */
`include "atom_params.svh"

module atom_alu (
    input  atom_pipe_pkg::ctrl_t  ctrl_i,
    input  logic [`ATOM_XLEN-1:0] rs1_i,
    input  logic [`ATOM_XLEN-1:0] rs2_i,
    input  logic [`ATOM_XLEN-1:0] imm_i,
    input  logic [`ATOM_XLEN-1:0] pc_i,
    output logic [`ATOM_XLEN-1:0] result_o
);
    logic [`ATOM_XLEN-1:0] op_a;
    logic [`ATOM_XLEN-1:0] op_b;

    assign op_a = ctrl_i.a_sel_pc  ? pc_i  : rs1_i;   // AUIPC, JAL, branches
    assign op_b = ctrl_i.b_sel_imm ? imm_i : rs2_i;

    always_comb begin
        case (ctrl_i.alu_op)
            atom_isa_pkg::ALU_ADD: result_o = op_a + op_b;
            atom_isa_pkg::ALU_SUB: result_o = op_a - op_b;
            atom_isa_pkg::ALU_SLL: result_o = op_a << op_b[4:0];
            atom_isa_pkg::ALU_XOR: result_o = op_a ^ op_b;
            atom_isa_pkg::ALU_SRL: result_o = op_a >> op_b[4:0];
            atom_isa_pkg::ALU_SRA: result_o = $signed(op_a) >>> op_b[4:0];
            atom_isa_pkg::ALU_OR:  result_o = op_a | op_b;
            default:               result_o = op_a & op_b;
        endcase
    end

endmodule

//--- hdl/atom_branch_cmp.sv
/*
 * Branch comparator
 * Signed and unsigned compare for branches and SLT/SLTU
 */
`include "atom_params.svh"

module atom_branch_cmp (
    input  atom_pipe_pkg::ctrl_t  ctrl_i,
    input  logic [`ATOM_XLEN-1:0] rs1_i,
    input  logic [`ATOM_XLEN-1:0] rs2_i,
    input  logic [`ATOM_XLEN-1:0] imm_i,
    output logic                  cmp_true_o
);
    logic [`ATOM_XLEN-1:0] cmp_b;

    assign cmp_b = ctrl_i.cmp_b_sel_imm ? imm_i : rs2_i;   // SLTI/SLTIU

    always_comb begin
        case (ctrl_i.cmp_op)
            atom_isa_pkg::CMP_ALWAYS: cmp_true_o = 1'b1;
            atom_isa_pkg::CMP_EQ:     cmp_true_o = (rs1_i == cmp_b);
            atom_isa_pkg::CMP_NE:     cmp_true_o = (rs1_i != cmp_b);
            atom_isa_pkg::CMP_LT:     cmp_true_o = ($signed(rs1_i) < $signed(cmp_b));
            atom_isa_pkg::CMP_GE:     cmp_true_o = ($signed(rs1_i) >= $signed(cmp_b));
            atom_isa_pkg::CMP_LTU:    cmp_true_o = (rs1_i < cmp_b);
            atom_isa_pkg::CMP_GEU:    cmp_true_o = (rs1_i >= cmp_b);
            default:                  cmp_true_o = 1'b0;
        endcase
    end

endmodule

//--- hdl/atom_mem_wb.sv
/*
 * Memory access and write-back
 * Store lane alignment, load extraction and register write data
 */
`include "atom_params.svh"

module atom_mem_wb (
    input  atom_pipe_pkg::ctrl_t     ctrl_i,
    input  logic [`ATOM_XLEN-1:0]    alu_result_i,
    input  logic [`ATOM_XLEN-1:0]    rs2_i,
    input  logic [`ATOM_XLEN-1:0]    imm_i,
    input  logic [`ATOM_XLEN-1:0]    link_addr_i,
    input  logic                     cmp_true_i,
    input  logic                     stall_ex_i,
    input  logic [`ATOM_XLEN-1:0]    dmem_data_i,
    output atom_pipe_pkg::dmem_req_t dmem_req_o,
    output logic                     dmem_valid_o,
    output logic                     rf_we_o,
    output logic [`ATOM_XLEN-1:0]    rf_data_o
);
    logic [1:0]            offs;        // Byte offset in the word
    logic [1:0]            ld_offs;
    logic [`ATOM_XLEN-1:0] lane;
    logic [`ATOM_XLEN-1:0] load_data;

    assign offs         = alu_result_i[1:0];
    assign dmem_valid_o = ctrl_i.mem_en;
    assign rf_we_o      = ctrl_i.rf_we & ~stall_ex_i;   // No write until the ack

    ////////////////////////////////////////
    // Store side
    always_comb begin
        dmem_req_o.addr  = {alu_result_i[`ATOM_XLEN-1:2], 2'b00};
        dmem_req_o.we    = ctrl_i.mem_we;
        dmem_req_o.sel   = 4'b1111;                      // Loads and word stores
        dmem_req_o.wdata = ctrl_i.mem_we ? rs2_i : '0;
        if (ctrl_i.mem_we) begin
            case (ctrl_i.mem_width)
                atom_isa_pkg::MEM_BYTE: begin
                    dmem_req_o.sel   = 4'b0001 << offs;
                    dmem_req_o.wdata = {24'd0, rs2_i[7:0]} << {offs, 3'b000};
                end
                atom_isa_pkg::MEM_HALF: begin
                    dmem_req_o.sel   = 4'b0011 << {offs[1], 1'b0};
                    dmem_req_o.wdata = {16'd0, rs2_i[15:0]} << {offs[1], 4'b0000};
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Load side
    assign ld_offs = (ctrl_i.mem_width == atom_isa_pkg::MEM_HALF) ? {offs[1], 1'b0} : offs;
    assign lane    = dmem_data_i >> {ld_offs, 3'b000};   // Wanted bytes to bit 0

    always_comb begin
        case (ctrl_i.mem_width)
            atom_isa_pkg::MEM_BYTE:
                load_data = {{24{~ctrl_i.mem_unsigned & lane[7]}}, lane[7:0]};
            atom_isa_pkg::MEM_HALF:
                load_data = {{16{~ctrl_i.mem_unsigned & lane[15]}}, lane[15:0]};
            default:
                load_data = dmem_data_i;
        endcase
    end

    always_comb begin
        case (ctrl_i.wb_src)
            atom_pipe_pkg::WB_IMM:  rf_data_o = imm_i;       // LUI
            atom_pipe_pkg::WB_LINK: rf_data_o = link_addr_i;
            atom_pipe_pkg::WB_ALU:  rf_data_o = alu_result_i;
            atom_pipe_pkg::WB_CMP:  rf_data_o = {{(`ATOM_XLEN-1){1'b0}}, cmp_true_i};
            atom_pipe_pkg::WB_LOAD: rf_data_o = load_data;
            default:                rf_data_o = '0;
        endcase
    end

endmodule

//--- hdl/atom_core.sv
/*
 * Atom two-stage RV32I core
 * Fetch in stage 1, decode/execute/memory/write-back in stage 2
 */
`include "atom_params.svh"

module atom_core (
    input  logic                     clk_i,
    input  logic                     rst_i,
    output logic [`ATOM_XLEN-1:0]    imem_addr_o,
    output logic                     imem_valid_o,
    input  logic [`ATOM_XLEN-1:0]    imem_data_i,
    input  logic                     imem_ack_i,
    output atom_pipe_pkg::dmem_req_t dmem_req_o,
    output logic                     dmem_valid_o,
    input  logic [`ATOM_XLEN-1:0]    dmem_data_i,
    input  logic                     dmem_ack_i
);
    logic [`ATOM_XLEN-1:0]      instr;
    logic [`ATOM_XLEN-1:0]      pc_old;
    logic [`ATOM_XLEN-1:0]      link_addr;
    logic                       stall_ex;
    logic [`ATOM_REG_IDX_W-1:0] rd_sel;
    logic [`ATOM_REG_IDX_W-1:0] rs1_sel;
    logic [`ATOM_REG_IDX_W-1:0] rs2_sel;
    logic [`ATOM_XLEN-1:0]      imm;
    atom_pipe_pkg::ctrl_t       ctrl;
    logic [`ATOM_XLEN-1:0]      rs1;
    logic [`ATOM_XLEN-1:0]      rs2;
    logic [`ATOM_XLEN-1:0]      alu_result;    // Also jump target and memory address
    logic                       cmp_true;
    logic                       rf_we;
    logic [`ATOM_XLEN-1:0]      rf_data;

    // Stage 1
    atom_fetch u_fetch (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_data_i(imem_data_i), .imem_ack_i(imem_ack_i),
        .jump_en_i(ctrl.jump_en), .cmp_true_i(cmp_true), .jump_target_i(alu_result),
        .dmem_valid_i(dmem_valid_o), .dmem_ack_i(dmem_ack_i),
        .imem_addr_o(imem_addr_o), .imem_valid_o(imem_valid_o),
        .instr_o(instr), .pc_old_o(pc_old), .link_addr_o(link_addr),
        .stall_ex_o(stall_ex)
    );

    // Stage 2
    atom_decode u_decode (
        .instr_i(instr), .rd_sel_o(rd_sel), .rs1_sel_o(rs1_sel), .rs2_sel_o(rs2_sel),
        .imm_o(imm), .ctrl_o(ctrl)
    );

    atom_regfile u_regfile (
        .clk_i(clk_i), .rst_i(rst_i),
        .rs1_sel_i(rs1_sel), .rs2_sel_i(rs2_sel), .rd_sel_i(rd_sel),
        .we_i(rf_we), .rd_data_i(rf_data), .rs1_o(rs1), .rs2_o(rs2)
    );

    atom_alu u_alu (
        .ctrl_i(ctrl), .rs1_i(rs1), .rs2_i(rs2), .imm_i(imm), .pc_i(pc_old),
        .result_o(alu_result)
    );

    atom_branch_cmp u_branch_cmp (
        .ctrl_i(ctrl), .rs1_i(rs1), .rs2_i(rs2), .imm_i(imm), .cmp_true_o(cmp_true)
    );

    atom_mem_wb u_mem_wb (
        .ctrl_i(ctrl), .alu_result_i(alu_result), .rs2_i(rs2), .imm_i(imm),
        .link_addr_i(link_addr), .cmp_true_i(cmp_true), .stall_ex_i(stall_ex),
        .dmem_data_i(dmem_data_i), .dmem_req_o(dmem_req_o), .dmem_valid_o(dmem_valid_o),
        .rf_we_o(rf_we), .rf_data_o(rf_data)
    );

endmodule

//--- verification/atom_core_tb.sv
/*
 * Atom core testbench
 * Builds a program, models both memories with random ack delay
 * and checks every store against a reference model
 */
`include "atom_params.svh"

module atom_core_tb;
    localparam int MARK = 'h7f0;                // Store here means a skipped op ran
    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data = '0;
    logic [31:0] dmem_rdata = '0;
    logic imem_valid;
    logic imem_ack = 1'b0;
    logic dmem_valid;
    logic dmem_ack = 1'b0;
    atom_pipe_pkg::dmem_req_t dmem_req;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:511];
    atom_pipe_pkg::dmem_req_t exp_q[$];
    int errors = 0;
    int stores = 0;
    int n_exp;
    int icnt = 0;                               // Fetch ack delay left
    int dcnt = 0;                               // Data ack delay left
    int pc = 0;
    int out = 'h600;                            // Next result slot
    int f3_of[10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};   // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    int f7_of[10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
    int br_f3[6]  = '{0, 1, 4, 5, 6, 7};               // BEQ BNE BLT BGE BLTU BGEU

    atom_core u_atom_core (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_addr_o(imem_addr), .imem_valid_o(imem_valid),
        .imem_data_i(imem_data), .imem_ack_i(imem_ack),
        .dmem_req_o(dmem_req), .dmem_valid_o(dmem_valid),
        .dmem_data_i(dmem_rdata), .dmem_ack_i(dmem_ack)
    );

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Instruction encoders
    function automatic logic [31:0] r_type(logic [31:0] f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction
    function automatic logic [31:0] i_type(logic [31:0] opc, f3, rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction
    function automatic logic [31:0] s_type(logic [31:0] f3, rs1, rs2, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction
    function automatic logic [31:0] b_type(logic [31:0] f3, rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction
    function automatic logic [31:0] j_type(logic [31:0] rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    ////////////////////////////////////////
    // Reference model
    function automatic logic branch_taken(int kind, logic [31:0] a, b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            3: return $signed(a) >= $signed(b);
            4: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // op 0..9 ALU, 10..13 LB LBU LH LHU of a at byte off, 14 plain b
    function automatic atom_pipe_pkg::dmem_req_t expected_store(int op, logic [31:0] a, b,
                                                               int off, logic [31:0] addr,
                                                               int width);
        atom_pipe_pkg::dmem_req_t r;
        logic [31:0] v;
        logic [31:0] sh;
        sh = a >> (8 * off);                    // Loaded lane to bit 0
        case (op)
            0: v = a + b;
            1: v = a - b;
            2: v = a << b[4:0];
            3: v = {31'd0, $signed(a) < $signed(b)};
            4: v = {31'd0, a < b};
            5: v = a ^ b;
            6: v = a >> b[4:0];
            7: v = $signed(a) >>> b[4:0];
            8: v = a | b;
            9: v = a & b;
            10: v = {{24{sh[7]}}, sh[7:0]};
            11: v = {24'd0, sh[7:0]};
            12: v = {{16{sh[15]}}, sh[15:0]};
            13: v = {16'd0, sh[15:0]};
            default: v = b;
        endcase
        r.addr = {addr[31:2], 2'b00};
        r.we   = 1'b1;
        case (width)
            0: begin
                r.sel   = 4'b0001 << addr[1:0];
                r.wdata = (v & 32'hff) << (8 * addr[1:0]);
            end
            1: begin
                r.sel   = 4'b0011 << addr[1:0];
                r.wdata = (v & 32'hffff) << (8 * addr[1:0]);
            end
            default: begin
                r.sel   = 4'b1111;
                r.wdata = v;
            end
        endcase
        return r;
    endfunction

    task automatic emit(logic [31:0] w);
        imem[pc] = w;
        pc++;
    endtask

    task automatic check_store(atom_pipe_pkg::dmem_req_t got);
        atom_pipe_pkg::dmem_req_t exp;
        stores++;
        if (exp_q.size() == 0) begin
            $display("Unexpected extra store to %h at time %0t", got.addr, $time);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            if (got.addr != exp.addr) begin
                $display("Mismatch at %0t: dmem_req_o.addr got %h expected %h", $time,
                         got.addr, exp.addr);
                errors++;
            end
            if (got.wdata != exp.wdata) begin
                $display("Mismatch at %0t: dmem_req_o.wdata got %h expected %h", $time,
                         got.wdata, exp.wdata);
                errors++;
            end
            if (got.sel != exp.sel) begin
                $display("Mismatch at %0t: dmem_req_o.sel got %h expected %h", $time,
                         got.sel, exp.sel);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Memory models, driven on the falling edge
    always @(negedge clk_i) begin
        imem_ack = 1'b0;
        if (!rst_i && imem_valid) begin
            if (icnt > 0) begin
                icnt--;                                         // Still waiting
            end else begin
                imem_ack  = 1'b1;
                imem_data = imem[imem_addr[9:2]];
                icnt      = $urandom % 4;
            end
        end
    end

    always @(negedge clk_i) begin
        dmem_ack = 1'b0;
        if (!rst_i && dmem_valid) begin
            if (dcnt > 0) begin
                dcnt--;
            end else begin
                dmem_ack   = 1'b1;                              // Handshake at next rising edge
                dcnt       = $urandom % 4;
                dmem_rdata = dmem[dmem_req.addr[10:2]];
                if (dmem_req.we) begin
                    check_store(dmem_req);                      // Compare against reference
                    for (int k = 0; k < 4; k++)
                        if (dmem_req.sel[k])
                            dmem[dmem_req.addr[10:2]][8*k +: 8] = dmem_req.wdata[8*k +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Program build and run control
    initial begin
        logic [31:0] a, b, bi, imm;
        int op, base, off, wd, q, cyc, swap;
        void'($urandom(74));
        for (int j = 0; j < 256; j++) imem[j] = `ATOM_NOP;
        for (int j = 0; j < 512; j++) dmem[j] = j * 32'h9e37_79b9 + 32'h1357_2468;
        for (int i = 0; i < 16; i++) begin
            base = 'h400 + 8 * i;
            a = $urandom;
            b = $urandom;
            if (i % 2) a[31] = 1'b1;                            // Negative for SRA and signed compare
            if (i >= 12)
                b = a;                                          // Equal pairs for BEQ BNE BGE
            else if (b == a)
                b = ~a;
            dmem[base >> 2] = a;
            dmem[(base >> 2) + 1] = b;
            emit(i_type(7'h03, 2, 1, 0, base));                 // lw x1
            emit(i_type(7'h03, 2, 2, 0, base + 4));             // lw x2
            op = i % 10;
            emit(r_type(f7_of[op], f3_of[op], 3, 1, 2));
            emit(s_type(2, 0, 3, out));
            exp_q.push_back(expected_store(op, a, b, 0, out, 2));
            out += 4;
            op = (i + 5) % 10;
            if (op == 1) op = 0;                                // No SUBI
            if (f3_of[op] == 1 || f3_of[op] == 5) begin
                imm = {20'd0, f7_of[op][6:0], b[4:0]};
                bi  = b;
            end else begin
                imm = {20'd0, b[11:0]};
                bi  = {{20{b[11]}}, b[11:0]};
            end
            emit(i_type(7'h13, f3_of[op], 4, 1, imm));
            emit(s_type(2, 0, 4, out));
            exp_q.push_back(expected_store(op, a, bi, 0, out, 2));
            out += 4;
            off = (i % 4 < 2) ? (i >> 2) & 3 : ((i >> 2) & 1) * 2;   // Sub-word load
            emit(i_type(7'h03, (i % 4 == 0) ? 0 : (i % 4 == 1) ? 4 : (i % 4 == 2) ? 1 : 5,
                        5, 0, base + off));
            emit(s_type(2, 0, 5, out));
            exp_q.push_back(expected_store(10 + i % 4, a, b, off, out, 2));
            out += 4;
            wd  = i % 2;                                        // sb or sh of b
            off = wd ? ((i >> 1) & 1) * 2 : (i >> 1) & 3;
            emit(s_type(wd, 0, 2, out + off));
            exp_q.push_back(expected_store(14, a, b, 0, out + off, wd));
            out += 4;
            swap = (i / 6) % 2;                                 // Swapped operands flip the outcome
            emit(b_type(br_f3[i % 6], swap ? 2 : 1, swap ? 1 : 2, 8));   // Skip marker when taken
            emit(s_type(2, 0, 1, MARK));
            if (!branch_taken(i % 6, swap ? b : a, swap ? a : b))
                exp_q.push_back(expected_store(14, 0, a, 0, MARK, 2));
        end
        q = pc * 4;                                             // JAL and link
        emit(j_type(5, 8));
        emit(s_type(2, 0, 0, MARK));
        emit(s_type(2, 0, 5, out));
        exp_q.push_back(expected_store(14, 0, q + 4, 0, out, 2));
        out += 4;
        q = (pc + 1) * 4;                                       // JALR via x6
        emit(i_type(7'h13, 0, 6, 0, q + 8));
        emit(i_type(7'h67, 0, 7, 6, 0));
        emit(s_type(2, 0, 0, MARK));
        emit(s_type(2, 0, 7, out));
        exp_q.push_back(expected_store(14, 0, q + 4, 0, out, 2));
        emit(j_type(0, 0));                                     // Park
        n_exp = exp_q.size();

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        for (cyc = 0; cyc < 20000 && stores < n_exp; cyc++)
            @(posedge clk_i);
        if (stores < n_exp) begin
            $display("Timeout: only %0d of %0d stores seen", stores, n_exp);
            errors++;
        end
        repeat (40) @(posedge clk_i);                           // Catch extra stores
        $display("Closing: %0d stores, %0d expected, %0d errors", stores, n_exp, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hdl/atom_isa_pkg.sv
hdl/atom_pipe_pkg.sv
hdl/atom_fetch.sv
hdl/atom_decode.sv
hdl/atom_regfile.sv
hdl/atom_alu.sv
hdl/atom_branch_cmp.sv
hdl/atom_mem_wb.sv
hdl/atom_core.sv
verification/atom_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the atom core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f build.f --top-module atom_core_tb -o atom_sim
./obj_dir/atom_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi
